// File: Bender.yml
package:
  name: uart_top

sources:
  - include_dirs:
      - include
    files:
      - src/uart_pkg.sv
      - src/uart_csr_if.sv
      - src/uart_csr_decode.sv
      - src/uart_core.sv
      - src/uart_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_uart_top.sv

// File: include/uart_consts.svh
/* UART peripheral constants
   divisor width and reset value, register map and control bits */

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// baud divisor, in clock cycles per bit
`define UART_DIV_W          16
`define UART_DIV_RST        16'd217   // 115200 baud at 25 MHz

// register offsets on the AXI4-Lite port
`define UART_ADDR_W         5
`define UART_ADDR_CTRL      5'h00
`define UART_ADDR_DIV       5'h04
`define UART_ADDR_TXDATA    5'h08
`define UART_ADDR_RXDATA    5'h0C
`define UART_ADDR_STATUS    5'h10

// control register bits
`define UART_CTRL_TXEN      0
`define UART_CTRL_RXEN      1
`define UART_CTRL_SRST      2   // self-clearing, reads as 0

`endif

// File: sim/tb_clk_gen.sv
/* testbench clock and reset
   40 ns clock, active-low reset held for 4 cycles */

`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o   = 1'b0;
      rst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      #2 rst_n_o = 1'b1;  // released just after an edge
   end

   always #20 clk_o = ~clk_o;

endmodule

// File: sim/tb_uart_top.sv
/* UART peripheral testbench
   AXI4-Lite register access, serial line model and flow control checks */

`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_uart_top;

   localparam int BUS_TIMEOUT  = 50;
   localparam int LINE_TIMEOUT = 2000;
   localparam int POLL_MAX     = 500;
   localparam logic [`UART_ADDR_W-1:0] ADDR_HOLE = 5'h14;

   logic clk, rst_n;
   logic [`UART_ADDR_W-1:0] awaddr, araddr;
   logic        awvalid, awready, wvalid, wready, bvalid, bready;
   logic        arvalid, arready, rvalid, rready;
   logic [31:0] wdata, rdata;
   logic [1:0]  bresp, rresp;
   logic        rxd, txd, cts, rts;

   logic [31:0] ctrl_m;  // register model
   logic [15:0] div_m;
   logic [31:0] rd;
   logic [1:0]  resp;
   logic [7:0]  byte_v;
   int          checks, errors, timeouts;
   int          i, n, lows;

   tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

   uart_top uut (
      .clk_i(clk), .rst_n_i(rst_n),
      .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
      .s_wdata_i(wdata), .s_wvalid_i(wvalid), .s_wready_o(wready),
      .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
      .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
      .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
      .rxd_i(rxd), .txd_o(txd), .cts_i(cts), .rts_o(rts)
   );

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("ERR %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   task automatic note_timeout(input string what);
      timeouts++;
      $display("timeout while waiting for %s", what);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // AXI4-Lite master
   ////////////////////////////////////////////////////////////////////////////
   task automatic write_reg(input logic [`UART_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic [1:0] resp_o);
      int cnt;
      @(posedge clk);
      #2;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      cnt = 0;
      @(negedge clk);
      while (!(awready && wready) && cnt < BUS_TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (!(awready && wready))
         note_timeout("awready and wready");
      @(posedge clk);  // accept edge
      #2;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      cnt = 0;
      while (!bvalid && cnt < BUS_TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (!bvalid)
         note_timeout("bvalid");
      resp_o = bresp;
   endtask

   task automatic read_reg(input logic [`UART_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp_o);
      int cnt;
      @(posedge clk);
      #2;
      araddr  = addr;
      arvalid = 1'b1;
      cnt = 0;
      @(negedge clk);
      while (!arready && cnt < BUS_TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (!arready)
         note_timeout("arready");
      @(posedge clk);
      #2;
      arvalid = 1'b0;
      cnt = 0;
      while (!rvalid && cnt < BUS_TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (!rvalid)
         note_timeout("rvalid");
      data   = rdata;
      resp_o = rresp;
   endtask

   // poll STATUS until the given bit is set
   task automatic wait_status_bit(input int idx, input string what);
      logic [31:0] st;
      logic [1:0]  r;
      int          cnt;
      cnt = 0;
      read_reg(`UART_ADDR_STATUS, st, r);
      while (!st[idx] && cnt < POLL_MAX) begin
         read_reg(`UART_ADDR_STATUS, st, r);
         cnt++;
      end
      if (!st[idx])
         note_timeout(what);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // serial line model
   ////////////////////////////////////////////////////////////////////////////
   task automatic hold_line(input logic val, input int cycles);
      rxd = val;
      repeat (cycles) @(posedge clk);
      #2;
   endtask

   task automatic send_frame(input logic [7:0] data);
      int k;
      @(posedge clk);
      #2;
      hold_line(1'b1, 2 * div_m + 2);  // idle long enough for the sync
      hold_line(1'b0, div_m);
      for (k = 0; k < 8; k++)
         hold_line(data[k], div_m);
      hold_line(1'b1, div_m);
   endtask

   // sample txd at mid-bit, starting from the falling edge
   task automatic catch_frame(input string name, input logic [7:0] exp);
      logic [7:0] got;
      logic       start_bit;
      logic       stop_bit;
      int         cnt, k;
      cnt = 0;
      @(negedge clk);
      while (txd && cnt < LINE_TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (txd) begin
         note_timeout({name, " start bit"});
         return;
      end
      repeat (div_m / 2) @(negedge clk);
      start_bit = txd;
      for (k = 0; k < 8; k++) begin
         repeat (div_m) @(negedge clk);
         got[k] = txd;  // LSB first
      end
      repeat (div_m) @(negedge clk);
      stop_bit = txd;
      check_value({name, " start"}, 32'd0, start_bit);
      check_value({name, " data"}, exp, got);
      check_value({name, " stop"}, 32'd1, stop_bit);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(32'hd66f_ccf2));
      awaddr   = '0;
      awvalid  = 1'b0;
      wdata    = '0;
      wvalid   = 1'b0;
      bready   = 1'b1;
      araddr   = '0;
      arvalid  = 1'b0;
      rready   = 1'b1;
      rxd      = 1'b1;
      cts      = 1'b1;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      ctrl_m = '0;
      div_m  = `UART_DIV_RST;

      n = 0;
      while (!rst_n && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (!rst_n)
         note_timeout("reset release");

      // reset values and register read-back
      read_reg(`UART_ADDR_STATUS, rd, resp);
      check_value("reset status", 32'd1, rd);
      check_value("reset status resp", 32'd0, resp);
      read_reg(`UART_ADDR_DIV, rd, resp);
      check_value("reset div", `UART_DIV_RST, rd);
      for (i = 0; i < 8; i++) begin
         rd = $urandom & ~(32'd1 << `UART_CTRL_SRST);
         write_reg(`UART_ADDR_CTRL, rd, resp);
         ctrl_m = rd & 32'h3;
         read_reg(`UART_ADDR_CTRL, rd, resp);
         check_value("ctrl readback", ctrl_m, rd);
      end
      for (i = 0; i < 8; i++) begin
         rd = $urandom;
         write_reg(`UART_ADDR_DIV, rd, resp);
         div_m = rd[15:0];
         read_reg(`UART_ADDR_DIV, rd, resp);
         check_value("div readback", div_m, rd);
      end
      write_reg(ADDR_HOLE, $urandom, resp);
      check_value("hole write resp", 32'd2, resp);
      read_reg(ADDR_HOLE, rd, resp);
      check_value("hole read resp", 32'd2, resp);
      read_reg(`UART_ADDR_DIV, rd, resp);
      check_value("div after hole", div_m, rd);
      read_reg(`UART_ADDR_CTRL, rd, resp);
      check_value("ctrl after hole", ctrl_m, rd);

      // transmit
      div_m = 16'd4 + 16'($urandom % 17);
      write_reg(`UART_ADDR_DIV, div_m, resp);
      write_reg(`UART_ADDR_CTRL, 32'd1, resp);
      ctrl_m = 32'd1;
      for (i = 0; i < 4; i++) begin
         wait_status_bit(0, "tx ready");
         byte_v = 8'($urandom);
         write_reg(`UART_ADDR_TXDATA, byte_v, resp);
         catch_frame("tx", byte_v);
      end

      // receive after a soft reset so the receiver restarts at this divisor
      write_reg(`UART_ADDR_CTRL, 32'd7, resp);
      ctrl_m = 32'd3;
      for (i = 0; i < 4; i++) begin
         byte_v = 8'($urandom);
         send_frame(byte_v);
         wait_status_bit(1, "rx ready");
         read_reg(`UART_ADDR_RXDATA, rd, resp);
         check_value("rx data", byte_v, rd);
         read_reg(`UART_ADDR_STATUS, rd, resp);
         check_value("rx status after read", 32'd1, rd);
      end

      // flow control
      @(negedge clk);
      check_value("rts empty", 32'd1, rts);
      byte_v = 8'($urandom);
      send_frame(byte_v);
      @(negedge clk);
      check_value("rts full", 32'd0, rts);
      read_reg(`UART_ADDR_RXDATA, rd, resp);
      check_value("flow rx data", byte_v, rd);
      @(posedge clk);
      @(negedge clk);
      check_value("rts after read", 32'd1, rts);
      @(posedge clk);
      #2 cts = 1'b0;
      repeat (4) @(posedge clk);  // past the synchronizer
      byte_v = 8'($urandom);
      write_reg(`UART_ADDR_TXDATA, byte_v, resp);
      read_reg(`UART_ADDR_STATUS, rd, resp);
      check_value("status while blocked", 32'd0, rd);
      lows = 0;
      repeat (5 * div_m) begin
         @(negedge clk);
         if (!txd)
            lows++;
      end
      check_value("txd low cycles with cts low", 32'd0, lows);
      @(posedge clk);
      #2 cts = 1'b1;
      catch_frame("cts release", byte_v);

      // soft reset in the middle of a frame
      wait_status_bit(0, "tx ready before srst");
      byte_v = 8'($urandom) & 8'hf0;  // low data bits keep the line low
      write_reg(`UART_ADDR_TXDATA, byte_v, resp);
      n = 0;
      @(negedge clk);
      while (txd && n < LINE_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (txd)
         note_timeout("start bit before srst");
      repeat (2 * div_m) @(negedge clk);
      write_reg(`UART_ADDR_CTRL, 32'd7, resp);
      @(posedge clk);
      @(negedge clk);
      check_value("txd after srst", 32'd1, txd);
      read_reg(`UART_ADDR_STATUS, rd, resp);
      check_value("status after srst", 32'd1, rd);
      read_reg(`UART_ADDR_CTRL, rd, resp);
      check_value("ctrl after srst", ctrl_m, rd);
      byte_v = 8'($urandom);
      write_reg(`UART_ADDR_TXDATA, byte_v, resp);
      catch_frame("tx after srst", byte_v);

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// File: src/uart_core.sv
/* UART 8N1 serial engine
   transmit and receive FSMs with CTS gating and a one-byte receive holding register */

`timescale 1ns/1ps

module uart_core (
   input  logic     clk_i,
   input  logic     rst_n_i,
   uart_csr_if.core csr,
   input  logic     rxd_i,
   output logic     txd_o,
   input  logic     cts_i,
   output logic     rts_o
);
   import uart_pkg::*;

   ////////////////////////////////////////////////////////////////////////////
   // transmitter
   ////////////////////////////////////////////////////////////////////////////
   tx_state_t    tx_state;
   logic [9:0]   tx_pattern;  // {stop, data, start}, LSB on the line
   uart_bitcnt_t tx_bitcnt;
   uart_cnt_t    tx_cyclecnt;
   uart_data_t   tx_data_q;
   logic         cts_meta;
   logic         cts_q;
   logic         tx_adv;
   logic         tx_accept;

   // two-flop CTS synchronizer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cts_meta <= 1'b0;
         cts_q    <= 1'b0;
      end else begin
         cts_meta <= cts_i;
         cts_q    <= cts_meta;
      end
   end

   assign tx_adv    = csr.tx_en & cts_q;          // freeze while disabled or blocked
   assign tx_accept = csr.tx_wr & csr.tx_ready;   // writes while busy are dropped
   assign txd_o     = tx_pattern[0];

   always_ff @(posedge clk_i) begin
      if (tx_accept)
         tx_data_q <= csr.tx_data;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tx_state     <= IDLE;
         tx_pattern   <= '1;
         tx_bitcnt    <= '0;
         tx_cyclecnt  <= uart_cnt_t'(1);
         csr.tx_ready <= 1'b1;
      end else if (csr.soft_rst) begin
         tx_state     <= IDLE;
         tx_pattern   <= '1;
         tx_bitcnt    <= '0;
         tx_cyclecnt  <= uart_cnt_t'(1);
         csr.tx_ready <= 1'b1;
      end else begin
         if (tx_accept)
            csr.tx_ready <= 1'b0;
         if (tx_adv) begin
            case (tx_state)
               IDLE: begin
                  tx_pattern  <= '1;  // line idles high
                  tx_bitcnt   <= '0;
                  tx_cyclecnt <= uart_cnt_t'(1);
                  if (tx_accept || !csr.tx_ready)  // new or stalled byte
                     tx_state <= LOAD;
               end
               LOAD: begin
                  tx_pattern <= {1'b1, tx_data_q, 1'b0};
                  tx_state   <= SEND;
               end
               SEND: begin
                  if (tx_cyclecnt == csr.div) begin
                     if (tx_bitcnt == 4'd9) begin  // stop bit done
                        tx_state     <= IDLE;
                        csr.tx_ready <= 1'b1;
                     end else begin
                        tx_pattern  <= {1'b0, tx_pattern[9:1]};
                        tx_bitcnt   <= tx_bitcnt + 4'd1;
                        tx_cyclecnt <= uart_cnt_t'(1);
                     end
                  end else begin
                     tx_cyclecnt <= tx_cyclecnt + uart_cnt_t'(1);
                  end
               end
               default: tx_state <= IDLE;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // receiver
   ////////////////////////////////////////////////////////////////////////////
   rx_state_t    rx_state;
   uart_bitcnt_t rx_bitcnt;
   uart_cnt_t    rx_cyclecnt;
   uart_data_t   rx_shift;
   logic         rx_sample;

   // mid-bit strobe for the 8 data bits
   assign rx_sample = csr.rx_en & ~csr.soft_rst & (rx_state == DATA) &
                      (rx_cyclecnt == csr.div) & (rx_bitcnt < 4'd8);

   assign rts_o = csr.rx_en & ~csr.rx_ready;  // hold off the peer while a byte waits

   always_ff @(posedge clk_i) begin
      if (rx_sample)
         rx_shift <= {rxd_i, rx_shift[7:1]};  // LSB arrives first
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         csr.rx_data <= '0;
      else if (rx_sample && (rx_bitcnt == 4'd7))
         csr.rx_data <= {rxd_i, rx_shift[7:1]};  // overwrites an unread byte
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rx_state     <= SYNC;
         rx_bitcnt    <= '0;
         rx_cyclecnt  <= uart_cnt_t'(1);
         csr.rx_ready <= 1'b0;
      end else if (csr.soft_rst) begin
         rx_state     <= SYNC;
         rx_bitcnt    <= '0;
         rx_cyclecnt  <= uart_cnt_t'(1);
         csr.rx_ready <= 1'b0;
      end else begin
         if (csr.rx_rd)
            csr.rx_ready <= 1'b0;
         if (csr.rx_en) begin
            case (rx_state)
               SYNC: begin
                  rx_cyclecnt <= uart_cnt_t'(1);
                  rx_bitcnt   <= '0;
                  if (rxd_i)
                     rx_state <= HIGH;
               end
               HIGH: begin
                  if (!rxd_i)
                     rx_state <= SYNC;  // glitch, start over
                  else if (rx_cyclecnt == csr.div)
                     rx_state <= WAIT_START;
                  else
                     rx_cyclecnt <= rx_cyclecnt + uart_cnt_t'(1);
               end
               WAIT_START: begin
                  rx_cyclecnt <= uart_cnt_t'(1);
                  rx_bitcnt   <= '0;
                  if (!rxd_i)
                     rx_state <= START;
               end
               START: begin
                  if (rx_cyclecnt == (csr.div >> 1)) begin
                     rx_cyclecnt <= uart_cnt_t'(1);
                     rx_state    <= rxd_i ? SYNC : DATA;  // false start resyncs
                  end else begin
                     rx_cyclecnt <= rx_cyclecnt + uart_cnt_t'(1);
                  end
               end
               DATA: begin
                  if (rx_cyclecnt == csr.div) begin
                     rx_cyclecnt <= uart_cnt_t'(1);
                     rx_bitcnt   <= rx_bitcnt + 4'd1;
                     if (rx_bitcnt == 4'd7)
                        csr.rx_ready <= 1'b1;  // last data bit sampled
                     if (rx_bitcnt == 4'd8)
                        rx_state <= WAIT_START;  // now mid stop bit
                  end else begin
                     rx_cyclecnt <= rx_cyclecnt + uart_cnt_t'(1);
                  end
               end
               default: rx_state <= SYNC;
            endcase
         end
      end
   end

endmodule

// File: src/uart_csr_decode.sv
/* UART AXI4-Lite register decode
   holds control and divisor, turns TXDATA/RXDATA accesses into core pulses */

`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_csr_decode (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [`UART_ADDR_W-1:0] s_awaddr_i,
   input  logic                    s_awvalid_i,
   output logic                    s_awready_o,
   input  logic [31:0]             s_wdata_i,
   input  logic                    s_wvalid_i,
   output logic                    s_wready_o,
   output logic [1:0]              s_bresp_o,
   output logic                    s_bvalid_o,
   input  logic                    s_bready_i,
   input  logic [`UART_ADDR_W-1:0] s_araddr_i,
   input  logic                    s_arvalid_i,
   output logic                    s_arready_o,
   output logic [31:0]             s_rdata_o,
   output logic [1:0]              s_rresp_o,
   output logic                    s_rvalid_o,
   input  logic                    s_rready_i,
   uart_csr_if.decode              csr
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic        wr_acc;
   logic        rd_acc;
   logic [31:0] rd_word;

   function automatic logic is_mapped(input logic [`UART_ADDR_W-1:0] addr);
      return (addr == `UART_ADDR_CTRL)   || (addr == `UART_ADDR_DIV)    ||
             (addr == `UART_ADDR_TXDATA) || (addr == `UART_ADDR_RXDATA) ||
             (addr == `UART_ADDR_STATUS);
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // write channel
   ////////////////////////////////////////////////////////////////////////////
   assign wr_acc      = s_awvalid_i & s_wvalid_i & ~s_bvalid_o;  // one write at a time
   assign s_awready_o = wr_acc;
   assign s_wready_o  = wr_acc;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         csr.tx_en    <= 1'b0;
         csr.rx_en    <= 1'b0;
         csr.soft_rst <= 1'b0;
         csr.div      <= `UART_DIV_RST;
         csr.tx_wr    <= 1'b0;
         s_bvalid_o   <= 1'b0;
         s_bresp_o    <= RESP_OKAY;
      end else begin
         csr.tx_wr    <= 1'b0;  // pulses
         csr.soft_rst <= 1'b0;
         if (s_bvalid_o && s_bready_i)
            s_bvalid_o <= 1'b0;
         if (wr_acc) begin
            s_bvalid_o <= 1'b1;
            s_bresp_o  <= is_mapped(s_awaddr_i) ? RESP_OKAY : RESP_SLVERR;
            case (s_awaddr_i)
               `UART_ADDR_CTRL: begin
                  csr.tx_en    <= s_wdata_i[`UART_CTRL_TXEN];
                  csr.rx_en    <= s_wdata_i[`UART_CTRL_RXEN];
                  csr.soft_rst <= s_wdata_i[`UART_CTRL_SRST];
               end
               `UART_ADDR_DIV:    csr.div   <= s_wdata_i[`UART_DIV_W-1:0];
               `UART_ADDR_TXDATA: csr.tx_wr <= 1'b1;  // lines up with bvalid
               default: ;                             // read-only or unmapped
            endcase
         end
      end
   end

   // byte to send, qualified by tx_wr
   always_ff @(posedge clk_i) begin
      if (wr_acc && (s_awaddr_i == `UART_ADDR_TXDATA))
         csr.tx_data <= s_wdata_i[7:0];
   end

   ////////////////////////////////////////////////////////////////////////////
   // read channel
   ////////////////////////////////////////////////////////////////////////////
   assign rd_acc      = s_arvalid_i & ~s_rvalid_o;
   assign s_arready_o = rd_acc;

   always_comb begin
      rd_word = '0;
      case (s_araddr_i)
         `UART_ADDR_CTRL: begin
            rd_word[`UART_CTRL_TXEN] = csr.tx_en;
            rd_word[`UART_CTRL_RXEN] = csr.rx_en;
         end
         `UART_ADDR_DIV:    rd_word[`UART_DIV_W-1:0] = csr.div;
         `UART_ADDR_RXDATA: rd_word[7:0] = csr.rx_data;
         `UART_ADDR_STATUS: begin
            rd_word[0] = csr.tx_ready;
            rd_word[1] = csr.rx_ready;
         end
         default: ;  // TXDATA and holes read as zero
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s_rvalid_o <= 1'b0;
         s_rresp_o  <= RESP_OKAY;
         csr.rx_rd  <= 1'b0;
      end else begin
         csr.rx_rd <= 1'b0;
         if (s_rvalid_o && s_rready_i)
            s_rvalid_o <= 1'b0;
         if (rd_acc) begin
            s_rvalid_o <= 1'b1;
            s_rresp_o  <= is_mapped(s_araddr_i) ? RESP_OKAY : RESP_SLVERR;
            csr.rx_rd  <= (s_araddr_i == `UART_ADDR_RXDATA);  // byte already captured
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_acc)
         s_rdata_o <= rd_word;
   end

endmodule

// File: src/uart_csr_if.sv
/* UART register-to-core link
   control, divisor and data access between the bus decode and the UART core */

`timescale 1ns/1ps

interface uart_csr_if;
   import uart_pkg::*;

   logic       tx_en;     // transmit enable
   logic       rx_en;     // receive enable
   logic       soft_rst;  // one-cycle pulse
   uart_div_t  div;
   logic       tx_wr;     // one-cycle pulse, tx_data valid
   uart_data_t tx_data;
   logic       rx_rd;     // one-cycle pulse, held byte consumed
   uart_data_t rx_data;
   logic       tx_ready;
   logic       rx_ready;

   modport decode (
      output tx_en, rx_en, soft_rst, div, tx_wr, tx_data, rx_rd,
      input  rx_data, tx_ready, rx_ready
   );

   modport core (
      input  tx_en, rx_en, soft_rst, div, tx_wr, tx_data, rx_rd,
      output rx_data, tx_ready, rx_ready
   );

endinterface

// File: src/uart_pkg.sv
/* UART shared types
   data, divisor and counter vectors plus the transmit and receive FSM states */

`include "uart_consts.svh"

package uart_pkg;

   typedef logic [7:0]             uart_data_t;    // one serial byte
   typedef logic [`UART_DIV_W-1:0] uart_div_t;     // cycles per bit
   typedef logic [`UART_DIV_W-1:0] uart_cnt_t;     // cycle count within a bit
   typedef logic [3:0]             uart_bitcnt_t;  // bit index within a frame

   // transmitter
   typedef enum logic [1:0] {
      IDLE,   // wait for a byte
      LOAD,   // build the frame pattern
      SEND    // shift the frame out
   } tx_state_t;

   // receiver
   typedef enum logic [2:0] {
      SYNC,        // wait for the line to go high
      HIGH,        // line must stay high for a full bit
      WAIT_START,  // wait for a falling edge
      START,       // confirm start at half a bit
      DATA         // sample data bits, then ride out the stop bit
   } rx_state_t;

endpackage

// File: src/uart_top.sv
/* UART peripheral top level
   AXI4-Lite register decode joined to the 8N1 serial core */

`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_top (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   // AXI4-Lite slave
   input  logic [`UART_ADDR_W-1:0] s_awaddr_i,
   input  logic                    s_awvalid_i,
   output logic                    s_awready_o,
   input  logic [31:0]             s_wdata_i,
   input  logic                    s_wvalid_i,
   output logic                    s_wready_o,
   output logic [1:0]              s_bresp_o,
   output logic                    s_bvalid_o,
   input  logic                    s_bready_i,
   input  logic [`UART_ADDR_W-1:0] s_araddr_i,
   input  logic                    s_arvalid_i,
   output logic                    s_arready_o,
   output logic [31:0]             s_rdata_o,
   output logic [1:0]              s_rresp_o,
   output logic                    s_rvalid_o,
   input  logic                    s_rready_i,
   // RS-232 side
   input  logic                    rxd_i,
   output logic                    txd_o,
   input  logic                    cts_i,
   output logic                    rts_o
);

   uart_csr_if csr_if ();

   uart_csr_decode u_decode (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .s_awaddr_i (s_awaddr_i),
      .s_awvalid_i(s_awvalid_i),
      .s_awready_o(s_awready_o),
      .s_wdata_i  (s_wdata_i),
      .s_wvalid_i (s_wvalid_i),
      .s_wready_o (s_wready_o),
      .s_bresp_o  (s_bresp_o),
      .s_bvalid_o (s_bvalid_o),
      .s_bready_i (s_bready_i),
      .s_araddr_i (s_araddr_i),
      .s_arvalid_i(s_arvalid_i),
      .s_arready_o(s_arready_o),
      .s_rdata_o  (s_rdata_o),
      .s_rresp_o  (s_rresp_o),
      .s_rvalid_o (s_rvalid_o),
      .s_rready_i (s_rready_i),
      .csr        (csr_if.decode)
   );

   uart_core u_core (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .csr    (csr_if.core),
      .rxd_i  (rxd_i),
      .txd_o  (txd_o),
      .cts_i  (cts_i),
      .rts_o  (rts_o)
   );

endmodule

// File: uart_top.f
+incdir+include
src/uart_pkg.sv
src/uart_csr_if.sv
src/uart_csr_decode.sv
src/uart_core.sv
src/uart_top.sv
sim/tb_clk_gen.sv
sim/tb_uart_top.sv
